// ==== hw/iotdf_pkg.sv ====
package iotdf_pkg;

	// ------------------------------------------------------------------
	// function select codes
	// ------------------------------------------------------------------
	localparam int fn_width = 3;

	localparam logic [fn_width-1:0] fn_crc      = 3'd3; // crc per block
	localparam logic [fn_width-1:0] fn_top2max  = 3'd4; // two largest per round
	localparam logic [fn_width-1:0] fn_last2min = 3'd5; // two smallest per round

	// ------------------------------------------------------------------
	// data geometry
	// ------------------------------------------------------------------
	localparam int byte_width       = 8;
	localparam int block_width      = 128;
	localparam int bytes_per_block  = 16;  // msb byte arrives first
	localparam int blocks_per_round = 8;

	// crc settings
	localparam int crc_width = 3;
	// x^3 + x + 1 with the x^3 term left implicit
	localparam logic [crc_width-1:0] crc_poly = 3'b011;

	typedef logic [byte_width-1:0]  byte_t;
	typedef logic [block_width-1:0] block_t;

endpackage

// ==== hw/iotdf_decode.sv ====
`timescale 1ns/1ps

module iotdf_decode (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            in_en,
	input  iotdf_pkg::byte_t                iot_in,
	input  logic [iotdf_pkg::fn_width-1:0]  fn_sel,
	output logic                            busy,
	output logic                            byte_valid,
	output iotdf_pkg::byte_t                byte_data,
	output logic                            byte_last,
	output logic                            round_last,
	output iotdf_pkg::block_t               block,
	output logic                            crc_en,
	output logic                            track_en,
	output logic                            track_max
);

	logic [$clog2(iotdf_pkg::bytes_per_block)-1:0]  byte_cnt;  // byte within block
	logic [$clog2(iotdf_pkg::blocks_per_round)-1:0] block_cnt; // block within round
	logic [1:0] stall_cnt; // remaining busy cycles after the first
	logic       accept;
	logic       block_end;

	assign accept    = in_en && !busy; // byte lost while busy
	assign block_end = &byte_cnt;      // both counters wrap on a power of two

	// ------------------------------------------------------------------
	// mode decode, the only place fn_sel is looked at
	// ------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			crc_en    <= 1'b0;
			track_en  <= 1'b0;
			track_max <= 1'b0;
		end else begin
			crc_en    <= fn_sel == iotdf_pkg::fn_crc;
			track_en  <= fn_sel == iotdf_pkg::fn_top2max || fn_sel == iotdf_pkg::fn_last2min;
			track_max <= fn_sel == iotdf_pkg::fn_top2max; // low selects min tracking
		end
	end

	// ------------------------------------------------------------------
	// byte intake and counting
	// ------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			byte_cnt   <= '0;
			block_cnt  <= '0;
			byte_valid <= 1'b0;
			byte_last  <= 1'b0;
			round_last <= 1'b0;
		end else begin
			byte_valid <= accept;
			byte_last  <= accept && block_end;
			round_last <= accept && block_end && (&block_cnt);
			if (accept) begin
				byte_cnt <= byte_cnt + 1'b1;
				if (block_end)
					block_cnt <= block_cnt + 1'b1;
			end
		end
	end

	// payload side, block shifts left so the first byte ends up on top
	always_ff @(posedge clk) begin
		if (accept) begin
			byte_data <= iot_in;
			block     <= {block[iotdf_pkg::block_width-iotdf_pkg::byte_width-1:0], iot_in};
		end
	end

	// stall after a round in tracker modes, busy rises the cycle after byte_last
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy      <= 1'b1; // held busy through reset
			stall_cnt <= '0;
		end else if (track_en && round_last) begin
			busy      <= 1'b1;
			stall_cnt <= 2'd3; // four busy cycles in total
		end else if (stall_cnt != '0) begin
			busy      <= 1'b1;
			stall_cnt <= stall_cnt - 1'b1;
		end else begin
			busy <= 1'b0;
		end
	end

endmodule

// ==== hw/iotdf_crc_unit.sv ====
`timescale 1ns/1ps

module iotdf_crc_unit (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             crc_en,
	input  logic                             byte_valid,
	input  iotdf_pkg::byte_t                 byte_data,
	input  logic                             byte_last,
	output logic                             crc_done,
	output logic [iotdf_pkg::crc_width-1:0]  crc_out
);

	logic [iotdf_pkg::crc_width-1:0] crc_r;     // running remainder
	logic [iotdf_pkg::crc_width-1:0] crc_byte;  // after this byte
	logic [iotdf_pkg::crc_width-1:0] crc_final; // after the three flush zeros

	// one long division step, bring down bit b and reduce when the top bit is set
	function automatic logic [iotdf_pkg::crc_width-1:0] crc_step(
		input logic [iotdf_pkg::crc_width-1:0] r,
		input logic                            b
	);
		logic [iotdf_pkg::crc_width-1:0] s;
		s = {r[iotdf_pkg::crc_width-2:0], b};
		return r[iotdf_pkg::crc_width-1] ? (s ^ iotdf_pkg::crc_poly) : s;
	endfunction

	// eight message bits per cycle, msb first
	always_comb begin
		crc_byte = crc_r;
		for (int i = iotdf_pkg::byte_width - 1; i >= 0; i--)
			crc_byte = crc_step(crc_byte, byte_data[i]);
		crc_final = crc_byte;
		for (int i = 0; i < iotdf_pkg::crc_width; i++)
			crc_final = crc_step(crc_final, 1'b0); // multiply by x^3
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			crc_r    <= '0;
			crc_done <= 1'b0;
		end else begin
			crc_done <= crc_en && byte_valid && byte_last;
			if (crc_en && byte_valid)
				crc_r <= byte_last ? '0 : crc_byte; // clean start for next block
		end
	end

	always_ff @(posedge clk) begin
		if (crc_en && byte_valid && byte_last)
			crc_out <= crc_final;
	end

endmodule

// ==== hw/iotdf_extremum_tracker.sv ====
`timescale 1ns/1ps

module iotdf_extremum_tracker (
	input  logic               clk,
	input  logic               rst,
	input  logic               track_en,
	input  logic               track_max,
	input  logic               byte_valid,
	input  iotdf_pkg::byte_t   byte_data,
	input  logic               byte_last,
	input  logic               round_last,
	input  iotdf_pkg::block_t  block,
	output logic               round_done,
	output iotdf_pkg::block_t  best,
	output iotdf_pkg::block_t  second
);

	logic [$clog2(iotdf_pkg::bytes_per_block)-1:0] byte_cnt;
	logic fresh;          // round empty, stored values are stale
	logic best_decided;   // unequal byte already seen
	logic best_gt;
	logic second_decided;
	logic second_gt;
	logic best_gt_fin;
	logic second_gt_fin;
	logic enter_best;
	logic enter_second;
	logic insert;
	iotdf_pkg::block_t empty_val;
	iotdf_pkg::block_t cur_best;
	iotdf_pkg::block_t cur_second;
	iotdf_pkg::byte_t  best_byte;
	iotdf_pkg::byte_t  second_byte;

	// byte n of a block counted from the top
	function automatic iotdf_pkg::byte_t pick_byte(
		input iotdf_pkg::block_t                             v,
		input logic [$clog2(iotdf_pkg::bytes_per_block)-1:0] n
	);
		return v[(iotdf_pkg::bytes_per_block - 1 - int'(n)) * iotdf_pkg::byte_width
			+: iotdf_pkg::byte_width];
	endfunction

	// ------------------------------------------------------------------
	// serial compare against the held pair
	// ------------------------------------------------------------------
	assign empty_val  = track_max ? '0 : '1;
	assign cur_best   = fresh ? empty_val : best;
	assign cur_second = fresh ? empty_val : second;

	assign best_byte   = pick_byte(cur_best, byte_cnt);
	assign second_byte = pick_byte(cur_second, byte_cnt);

	// first unequal byte decides, a full match counts as not greater
	assign best_gt_fin   = best_decided ? best_gt : (byte_data > best_byte);
	assign second_gt_fin = second_decided ? second_gt : (byte_data > second_byte);

	// max needs strictly greater, min takes less or equal
	assign enter_best   = track_max ? best_gt_fin : !best_gt_fin;
	assign enter_second = track_max ? second_gt_fin : !second_gt_fin;
	assign insert       = track_en && byte_valid && byte_last;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			byte_cnt       <= '0;
			best_decided   <= 1'b0;
			best_gt        <= 1'b0;
			second_decided <= 1'b0;
			second_gt      <= 1'b0;
		end else if (byte_valid) begin
			if (byte_last) begin
				byte_cnt       <= '0;
				best_decided   <= 1'b0;
				best_gt        <= 1'b0;
				second_decided <= 1'b0;
				second_gt      <= 1'b0;
			end else begin
				byte_cnt       <= byte_cnt + 1'b1;
				best_decided   <= best_decided || (byte_data != best_byte);
				best_gt        <= best_gt_fin;
				second_decided <= second_decided || (byte_data != second_byte);
				second_gt      <= second_gt_fin;
			end
		end
	end

	// ------------------------------------------------------------------
	// round bookkeeping
	// ------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fresh      <= 1'b1;
			round_done <= 1'b0;
		end else begin
			round_done <= insert && round_last;
			if (insert)
				fresh <= round_last; // empty again once the round closes
		end
	end

	// best and second hold still after round_done until the next insert,
	// the result block reads them two and three cycles later
	always_ff @(posedge clk) begin
		if (insert) begin
			if (enter_best) begin
				best   <= block;
				second <= cur_best; // old best moves down
			end else begin
				best   <= cur_best;
				second <= enter_second ? block : cur_second;
			end
		end
	end

endmodule

// ==== hw/iotdf_result.sv ====
`timescale 1ns/1ps

module iotdf_result (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             crc_done,
	input  logic [iotdf_pkg::crc_width-1:0]  crc_out,
	input  logic                             round_done,
	input  iotdf_pkg::block_t                best,
	input  iotdf_pkg::block_t                second,
	output logic                             valid,
	output iotdf_pkg::block_t                iot_out
);

	// round output steps
	typedef enum logic [1:0] {
		seq_idle,
		seq_wait,   // one spare cycle so both words sit at the end of busy
		seq_second  // best on the output, second goes next
	} seq_t;

	seq_t seq;

	// ------------------------------------------------------------------
	// valid and sequencer
	// ------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			seq   <= seq_idle;
			valid <= 1'b0;
		end else begin
			valid <= crc_done || (seq != seq_idle); // single pulse for crc
			case (seq)
				seq_idle:   if (round_done) seq <= seq_wait;
				seq_wait:   seq <= seq_second;
				seq_second: seq <= seq_idle;
				default:    seq <= seq_idle;
			endcase
		end
	end

	// output word, loaded in the same edge valid rises
	always_ff @(posedge clk) begin
		if (crc_done)
			iot_out <= iotdf_pkg::block_t'(crc_out); // remainder zero extended
		else if (seq == seq_wait)
			iot_out <= best;
		else if (seq == seq_second)
			iot_out <= second;
	end

endmodule

// ==== hw/iotdf_top.sv ====
`timescale 1ns/1ps

module iotdf_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            in_en,
	input  iotdf_pkg::byte_t                iot_in,
	input  logic [iotdf_pkg::fn_width-1:0]  fn_sel,
	output logic                            busy,
	output logic                            valid,
	output iotdf_pkg::block_t               iot_out
);

	// ------------------------------------------------------------------
	// decode to execute
	// ------------------------------------------------------------------
	logic              byte_valid;
	iotdf_pkg::byte_t  byte_data;
	logic              byte_last;
	logic              round_last;
	iotdf_pkg::block_t block;
	logic              crc_en;
	logic              track_en;
	logic              track_max;

	// execute to result
	logic                            crc_done;
	logic [iotdf_pkg::crc_width-1:0] crc_out;
	logic                            round_done;
	iotdf_pkg::block_t               best;
	iotdf_pkg::block_t               second;

	iotdf_decode iotdf_decode_inst (
		.clk        (clk),
		.rst        (rst),
		.in_en      (in_en),
		.iot_in     (iot_in),
		.fn_sel     (fn_sel),
		.busy       (busy),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_last  (byte_last),
		.round_last (round_last),
		.block      (block),
		.crc_en     (crc_en),
		.track_en   (track_en),
		.track_max  (track_max)
	);

	iotdf_crc_unit iotdf_crc_unit_inst (
		.clk        (clk),
		.rst        (rst),
		.crc_en     (crc_en),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_last  (byte_last),
		.crc_done   (crc_done),
		.crc_out    (crc_out)
	);

	iotdf_extremum_tracker iotdf_extremum_tracker_inst (
		.clk        (clk),
		.rst        (rst),
		.track_en   (track_en),
		.track_max  (track_max),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_last  (byte_last),
		.round_last (round_last),
		.block      (block),
		.round_done (round_done),
		.best       (best),
		.second     (second)
	);

	iotdf_result iotdf_result_inst (
		.clk        (clk),
		.rst        (rst),
		.crc_done   (crc_done),
		.crc_out    (crc_out),
		.round_done (round_done),
		.best       (best),
		.second     (second),
		.valid      (valid),
		.iot_out    (iot_out)
	);

endmodule

// ==== tests/iotdf_properties.sv ====
`timescale 1ns/1ps

module iotdf_properties (
	input logic                           clk,
	input logic                           rst,
	input logic [iotdf_pkg::fn_width-1:0] fn_sel,
	input logic                           busy,
	input logic                           valid
);

	logic crc_mode;
	logic tracker_mode;

	assign crc_mode     = fn_sel == iotdf_pkg::fn_crc;
	assign tracker_mode = fn_sel == iotdf_pkg::fn_top2max || fn_sel == iotdf_pkg::fn_last2min;

	// ------------------------------------------------------------------
	// output handshake
	// ------------------------------------------------------------------
	no_valid_in_reset: assert property (@(posedge clk) rst |-> !valid)
		else $error("valid high while reset is asserted");

	// crc remainder is a single pulse
	crc_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		(crc_mode && valid) |=> !valid)
		else $error("valid held longer than one cycle in crc mode");

	// round words sit inside the stall window
	tracker_valid_in_busy: assert property (@(posedge clk) disable iff (rst)
		(tracker_mode && $rose(valid)) |-> busy)
		else $error("valid rose in tracker mode while busy was low");

endmodule

bind iotdf_top iotdf_properties iotdf_properties_inst (
	.clk    (clk),
	.rst    (rst),
	.fn_sel (fn_sel),
	.busy   (busy),
	.valid  (valid)
);

// ==== tests/iotdf_tb.sv ====
`timescale 1ns/1ps

module iotdf_tb;

	typedef iotdf_pkg::block_t block_t;

	localparam int          clk_period   = 10;
	localparam int          timeout      = 200; // cycles per wait
	localparam logic [31:0] seed         = 32'h99;
	localparam int          stream_bytes = 2 * iotdf_pkg::bytes_per_block
		* iotdf_pkg::blocks_per_round;

	logic                           clk;
	logic                           rst;
	logic                           in_en;
	iotdf_pkg::byte_t               iot_in;
	logic [iotdf_pkg::fn_width-1:0] fn_sel;
	logic                           busy;
	logic                           valid;
	block_t                         iot_out;

	int     checks;
	int     errors;
	block_t expected_q[$]; // round words still due

	iotdf_top iotdf_top_inst (
		.clk     (clk),
		.rst     (rst),
		.in_en   (in_en),
		.iot_in  (iot_in),
		.fn_sel  (fn_sel),
		.busy    (busy),
		.valid   (valid),
		.iot_out (iot_out)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	task automatic tick(); // inputs change and outputs are read 1 ns after the edge
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input block_t actual, input block_t expected, input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, actual, expected);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_before);
	endtask

	task automatic apply_reset(input logic [iotdf_pkg::fn_width-1:0] mode);
		rst    = 1'b1;
		in_en  = 1'b0;
		iot_in = '0;
		fn_sel = mode; // only changes under reset
		expected_q.delete();
		repeat (16) tick();
		check_value(block_t'(busy), block_t'(1'b1), "busy during reset");
		rst = 1'b0;
		tick();
	endtask

	function automatic block_t random_block();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// block times x^3, long division by x^3+x+1
	function automatic logic [iotdf_pkg::crc_width-1:0] ref_crc(input block_t blk);
		logic [iotdf_pkg::block_width+iotdf_pkg::crc_width-1:0] m;
		logic [iotdf_pkg::crc_width:0]                          gen;
		gen = {1'b1, iotdf_pkg::crc_poly};
		m   = {blk, {iotdf_pkg::crc_width{1'b0}}};
		for (int i = iotdf_pkg::block_width + iotdf_pkg::crc_width - 1;
				i >= iotdf_pkg::crc_width; i--)
			if (m[i])
				m[i -: iotdf_pkg::crc_width+1] = m[i -: iotdf_pkg::crc_width+1] ^ gen;
		return m[iotdf_pkg::crc_width-1:0];
	endfunction

	// insertion sort, smallest first
	task automatic sort_round(input block_t blks[$], output block_t sorted[$]);
		block_t tmp;
		sorted = blks;
		for (int i = 1; i < sorted.size(); i++)
			for (int j = i; j > 0 && sorted[j-1] > sorted[j]; j--) begin
				tmp         = sorted[j];
				sorted[j]   = sorted[j-1];
				sorted[j-1] = tmp;
			end
	endtask

	// equal blocks have equal values, so either tie order gives the same words
	task automatic queue_results(input block_t blks[$]);
		block_t sorted[$];
		sort_round(blks, sorted);
		if (fn_sel == iotdf_pkg::fn_top2max) begin
			expected_q.push_back(sorted[sorted.size()-1]);
			expected_q.push_back(sorted[sorted.size()-2]);
		end else begin
			expected_q.push_back(sorted[0]);
			expected_q.push_back(sorted[1]);
		end
	endtask

	// ------------------------------------------------------------------
	// driver and response waits
	// ------------------------------------------------------------------
	task automatic send_block(input block_t blk);
		int waited;
		for (int i = 0; i < iotdf_pkg::bytes_per_block; i++) begin
			iot_in = blk[(iotdf_pkg::bytes_per_block-1-i)*iotdf_pkg::byte_width
				+: iotdf_pkg::byte_width]; // msb byte first
			in_en  = 1'b1;
			waited = 0;
			while (busy && waited < timeout) begin // hold the byte through a stall
				tick();
				waited++;
			end
			if (busy)
				report_error("busy never dropped while a byte was waiting");
			tick(); // accepting edge
		end
		in_en = 1'b0;
	endtask

	task automatic send_round(input block_t blks[$]);
		foreach (blks[i])
			send_block(blks[i]);
	endtask

	// counts cycles from the edge that took the last byte
	task automatic wait_valid(output int cycles);
		cycles = 0;
		while (!valid && cycles < timeout) begin
			tick();
			cycles++;
		end
		if (!valid)
			report_error("valid never rose after the last byte was sent");
	endtask

	task automatic check_round(input block_t blks[$]);
		int cycles;
		queue_results(blks);
		wait_valid(cycles);
		check_value(block_t'(cycles), block_t'(3), "cycles to best word");
		check_value(block_t'(busy), block_t'(1'b1), "busy with best word");
		check_value(iot_out, expected_q.pop_front(), "best block");
		tick();
		check_value(block_t'(valid), block_t'(1'b1), "valid with second word");
		check_value(iot_out, expected_q.pop_front(), "second block");
		tick();
		check_value(block_t'(valid), block_t'(1'b0), "valid after second word");
	endtask

	task automatic take_result();
		if (valid) begin
			if (expected_q.size() == 0)
				report_error("valid rose with no round result due");
			else
				check_value(iot_out, expected_q.pop_front(), "streamed round word");
		end
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------
	task automatic test_idle();
		int err0;
		err0 = errors;
		apply_reset(iotdf_pkg::fn_crc);
		repeat (20) begin // no bytes offered
			check_value(block_t'(busy), block_t'(1'b0), "busy while idle");
			check_value(block_t'(valid), block_t'(1'b0), "valid while idle");
			tick();
		end
		report_test("idle", err0);
	endtask

	task automatic test_crc();
		int     err0;
		int     cycles;
		block_t blk;
		err0 = errors;
		apply_reset(iotdf_pkg::fn_crc);
		repeat (10) begin
			blk = random_block();
			send_block(blk);
			wait_valid(cycles);
			check_value(block_t'(cycles), block_t'(2), "cycles to crc word");
			check_value(iot_out, block_t'(ref_crc(blk)), "crc remainder");
			tick();
			check_value(block_t'(valid), block_t'(1'b0), "valid after crc word");
		end
		report_test("crc", err0);
	endtask

	task automatic test_max();
		int     err0;
		block_t blks[$];
		err0 = errors;
		apply_reset(iotdf_pkg::fn_top2max);
		repeat (iotdf_pkg::blocks_per_round) blks.push_back(random_block());
		send_round(blks);
		check_round(blks);
		report_test("top2max", err0);
	endtask

	task automatic test_min();
		int     err0;
		block_t blks[$];
		err0 = errors;
		apply_reset(iotdf_pkg::fn_last2min);
		// round one holds a very small block that must not leak forward
		repeat (iotdf_pkg::blocks_per_round) blks.push_back(random_block());
		blks[3] = block_t'(1);
		send_round(blks);
		check_round(blks);
		blks.delete();
		repeat (iotdf_pkg::blocks_per_round) blks.push_back(random_block());
		blks[2] = block_t'(8'h1f); // duplicated minimum
		blks[6] = block_t'(8'h1f);
		send_round(blks);
		check_round(blks);
		report_test("last2min", err0);
	endtask

	task automatic test_busy_drop();
		int     err0;
		int     nbytes;
		int     offered;
		int     waited;
		block_t cur;
		block_t round_blks[$];
		err0 = errors;
		apply_reset(iotdf_pkg::fn_top2max);
		nbytes  = 0;
		offered = 0;
		cur     = '0;
		in_en   = 1'b1; // stays high through the stall
		while (nbytes < stream_bytes && offered < stream_bytes + timeout) begin
			iot_in = iotdf_pkg::byte_t'($urandom); // new byte every cycle
			offered++;
			if (!busy) begin // next edge takes it
				nbytes++;
				cur = {cur[iotdf_pkg::block_width-iotdf_pkg::byte_width-1:0], iot_in};
				if (nbytes % iotdf_pkg::bytes_per_block == 0)
					round_blks.push_back(cur);
				if (round_blks.size() == iotdf_pkg::blocks_per_round) begin
					queue_results(round_blks);
					round_blks.delete();
				end
			end
			tick();
			take_result();
		end
		in_en = 1'b0;
		check_value(block_t'(offered - nbytes), block_t'(4), "bytes dropped while busy");
		waited = 0;
		while (expected_q.size() > 0 && waited < timeout) begin
			tick();
			waited++;
			take_result();
		end
		if (expected_q.size() > 0)
			report_error("round results still missing after the stream stopped");
		tick();
		check_value(block_t'(valid), block_t'(1'b0), "valid after last round");
		report_test("busy_drop", err0);
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		rst    = 1'b1;
		in_en  = 1'b0;
		iot_in = '0;
		fn_sel = iotdf_pkg::fn_crc;
		checks = 0;
		errors = 0;
		void'($urandom(seed));
		test_idle();
		test_crc();
		test_max();
		test_min();
		test_busy_drop();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== build.f ====
hw/iotdf_pkg.sv
hw/iotdf_decode.sv
hw/iotdf_crc_unit.sv
hw/iotdf_extremum_tracker.sv
hw/iotdf_result.sv
hw/iotdf_top.sv
tests/iotdf_properties.sv
tests/iotdf_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the iotdf testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module iotdf_tb -f build.f -o iotdf_sim

status=0
./obj_dir/iotdf_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "Test passed" sim.log; then
	echo "run.sh: simulation ok"
else
	echo "run.sh: simulation reported a failure, see sim.log"
	exit 1
fi
